// File: bench/rename_tb.sv
`timescale 1ns/1ns

module rename_tb;

   import rename_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int OP_IDLE = 0;
   localparam int OP_REN  = 1;                 // Rename with a destination
   localparam int OP_LOOK = 2;                 // Rename of sources only
   localparam int OP_RND  = 3;                 // Rename with LFSR picked registers
   localparam int OP_TAKE = 4;
   localparam int OP_RES  = 5;
   localparam int OP_RST  = 6;
   localparam int OP_FREE = 7;

   logic clk, rst_n, rename_valid, has_dst, chk_take, resolve_valid, restore_valid, free_valid;
   logic [AREG_W-1:0] src_a, src_b, dst;
   logic [CHK_W-1:0]  restore_id, chk_id;
   logic [PREG_W-1:0] free_preg, phys_src_a, phys_src_b, phys_dst;
   logic              stall, chk_full;

   // One table entry per cycle
   // An exp of -1 leaves the check to the model alone
   int op_q[$], x_q[$], y_q[$], z_q[$], exp_q[$];
   int cycles;
   logic [15:0] lfsr = 16'h0001;

   // ======================================
   // Reference model state
   // ======================================
   logic [PREG_W-1:0] m_map [AREGS];
   logic [PREGS-1:0]  m_avail;
   logic [PREG_W-1:0] snap_map [NCHECK][AREGS];
   logic [PREGS-1:0]  snap_avail [NCHECK];
   logic [CHK_W-1:0]  m_head, m_tail;
   logic [CHK_W:0]    m_count;                 // Live slots that reach NCHECK when full

   rename_top rename_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run(string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic expect_equal(string name, int got, int exp);
      assert (got == exp)
         else stop_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // Galois LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic int take_bits(int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr[0]);           // One step per bit taken
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic int lowest_free(logic [PREGS-1:0] bits);
      int idx;
      idx = -1;
      for (int i = 0; i < PREGS; i++) begin
         if (bits[i] && idx < 0) idx = i;
      end
      return idx;
   endfunction

   task automatic add_step(int op, int x, int y, int z, int exp);
      op_q.push_back(op);
      x_q.push_back(x);
      y_q.push_back(y);
      z_q.push_back(z);
      exp_q.push_back(exp);
   endtask

   task automatic drive(int op, int x, int y, int z);
      rename_valid  <= op inside {OP_REN, OP_LOOK, OP_RND};
      has_dst       <= op inside {OP_REN, OP_RND};
      src_a         <= AREG_W'(x);
      src_b         <= AREG_W'(y);
      dst           <= AREG_W'(z);
      chk_take      <= op == OP_TAKE;
      resolve_valid <= op == OP_RES;
      restore_valid <= op == OP_RST;
      restore_id    <= CHK_W'(x);
      free_valid    <= op == OP_FREE;
      free_preg     <= PREG_W'(x);
   endtask

   // Compare every output with the model, then apply the coming edge to the model
   task automatic check_and_update(int op, int exp);
      int lf;
      lf = lowest_free(m_avail);
      expect_equal("phys_src_a", int'(phys_src_a), int'(m_map[src_a]));
      expect_equal("phys_src_b", int'(phys_src_b), int'(m_map[src_b]));
      expect_equal("stall", int'(stall), int'(has_dst && lf < 0));
      if (lf >= 0) expect_equal("phys_dst", int'(phys_dst), lf);
      expect_equal("chk_id", int'(chk_id), int'(m_tail));
      expect_equal("chk_full", int'(chk_full), int'(int'(m_count) == NCHECK));
      if (exp >= 0 && op == OP_TAKE) expect_equal("chk_id", int'(chk_id), exp);
      if (exp >= 0 && op != OP_TAKE) expect_equal("phys_dst", int'(phys_dst), exp);
      case (op)
         OP_REN, OP_RND: if (lf >= 0) begin
            m_map[dst]  = PREG_W'(lf);            // Stalled renames leave the model alone
            m_avail[lf] = 1'b0;
         end
         OP_TAKE: begin
            for (int a = 0; a < AREGS; a++) snap_map[m_tail][a] = m_map[a];
            snap_avail[m_tail] = m_avail;
            m_tail  = m_tail + 1'b1;
            m_count = m_count + 1'b1;
         end
         OP_RES: begin
            m_head  = m_head + 1'b1;               // Oldest slot retires
            m_count = m_count - 1'b1;
         end
         OP_RST: begin
            for (int a = 0; a < AREGS; a++) m_map[a] = snap_map[restore_id][a];
            m_avail = snap_avail[restore_id];
            m_tail  = restore_id;                  // Restored slot and younger ones are dropped
            m_count = {1'b0, restore_id - m_head};
         end
         OP_FREE: m_avail[free_preg] = 1'b1;
         default: ;
      endcase
   endtask

   task automatic build_table();
      for (int i = 0; i < AREGS; i += 2) add_step(OP_LOOK, i, i + 1, 0, -1);  // Identity map
      add_step(OP_REN, 0, 0, 0, 8);                // First allocations come in order
      add_step(OP_REN, 0, 0, 1, 9);
      add_step(OP_REN, 0, 1, 2, 10);
      add_step(OP_LOOK, 0, 1, 0, -1);
      for (int i = 0; i < 21; i++) add_step(OP_RND, 0, 0, 0, -1);  // Drains the free list
      add_step(OP_REN, 5, 6, 5, -1);               // Stalls with no preg left
      add_step(OP_IDLE, 0, 0, 0, -1);
      add_step(OP_FREE, 3, 0, 0, -1);
      add_step(OP_REN, 4, 5, 4, 3);                // Takes exactly the freed preg
      for (int p = 0; p < 3; p++) add_step(OP_FREE, p, 0, 0, -1);
      add_step(OP_TAKE, 0, 0, 0, 0);
      add_step(OP_REN, 6, 7, 6, 0);
      add_step(OP_REN, 6, 7, 7, 1);
      add_step(OP_RST, 0, 0, 0, -1);
      add_step(OP_LOOK, 6, 7, 0, -1);              // Earlier mappings are back
      add_step(OP_REN, 6, 7, 6, 0);                // So is the earlier lowest free preg
      for (int k = 0; k < NCHECK; k++) add_step(OP_TAKE, 0, 0, 0, k);
      add_step(OP_RES, 0, 0, 0, -1);               // Sees chk_full high before it retires
      add_step(OP_IDLE, 0, 0, 0, -1);
      add_step(OP_RST, 1, 0, 0, -1);
      add_step(OP_TAKE, 0, 0, 0, 1);
      add_step(OP_IDLE, 0, 0, 0, -1);
   endtask

   // ======================================
   // Watchdog
   // ======================================
   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > op_q.size() + RESET_CYCLES + 20)
            stop_run($sformatf("Timeout after %0d cycles, the step table never finished", cycles));
      end
   end

   initial begin
      int x, y, z;
      rst_n = 1'b0;
      drive(OP_IDLE, 0, 0, 0);
      build_table();
      for (int i = 0; i < AREGS; i++) m_map[i] = PREG_W'(i);
      m_avail = {PREGS{1'b1}};
      for (int i = 0; i < AREGS; i++) m_avail[i] = 1'b0;  // Held by the identity map
      m_head  = '0;
      m_tail  = '0;
      m_count = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int s = 0; s < op_q.size(); s++) begin
         @(posedge clk);
         x = x_q[s];
         y = y_q[s];
         z = z_q[s];
         if (op_q[s] == OP_RND) begin
            x = take_bits(AREG_W);
            y = take_bits(AREG_W);
            z = take_bits(AREG_W);
         end
         drive(op_q[s], x, y, z);
         @(negedge clk);                           // Outputs have settled by mid cycle
         check_and_update(op_q[s], exp_q[s]);
      end
      @(posedge clk);
      drive(OP_IDLE, 0, 0, 0);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: rename.f
rtl/rename_pkg.sv
rtl/checkpoint_ram.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/checkpoint_alloc.sv
rtl/rename_top.sv
bench/rename_tb.sv

// File: rtl/checkpoint_alloc.sv
`timescale 1ns/1ns

module checkpoint_alloc (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       take,        // New branch wants a slot
   input  logic                       resolve,     // Oldest branch resolved correctly
   input  logic                       restore,     // Mispredict rolls back to restore_id
   input  logic [rename_pkg::CHK_W-1:0] restore_id,
   output logic [rename_pkg::CHK_W-1:0] chk_id,      // Slot the next take will use
   output logic                       chk_full
);

   import rename_pkg::*;

   logic [CHK_W-1:0] head;                     // Oldest slot in use
   logic [CHK_W-1:0] tail;                     // Next slot to hand out
   logic [CHK_W:0]   count;                    // Slots in use, one bit wider to hold NCHECK
   logic [CHK_W-1:0] head_nxt;
   logic [CHK_W-1:0] live_ofs;                 // Distance of restore_id from the head

   assign head_nxt = resolve ? head + 1'b1 : head;
   assign live_ofs = restore_id - head;        // Wraps around the ring for free

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         head <= head_nxt;
         if (restore) begin
            tail  <= restore_id;                // The restored slot and younger ones go back
            count <= {1'b0, restore_id - head_nxt};
         end else begin
            tail  <= take ? tail + 1'b1 : tail;
            count <= count + {{CHK_W{1'b0}}, take} - {{CHK_W{1'b0}}, resolve};
         end
      end
   end

   assign chk_id   = tail;
   assign chk_full = (count == (CHK_W + 1)'(NCHECK));

   // ======================================
   // Ring protocol checks
   // ======================================
   a_take_not_full : assert property (@(posedge clk) disable iff (!rst_n)
      take |-> !chk_full)
      else $error("checkpoint_alloc: take while all slots busy");

   a_resolve_not_empty : assert property (@(posedge clk) disable iff (!rst_n)
      resolve |-> (count != '0))
      else $error("checkpoint_alloc: resolve with no slot in use");

   // Only a slot between head and tail holds a live snapshot
   a_restore_live : assert property (@(posedge clk) disable iff (!rst_n)
      restore |-> ({1'b0, live_ofs} < count))
      else $error("checkpoint_alloc: restore of free slot %0d", restore_id);

endmodule

// File: rtl/checkpoint_ram.sv
`timescale 1ns/1ns

module checkpoint_ram (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        ena,     // Port A enable
   input  logic                        wea,     // Port A write strobe
   input  logic [rename_pkg::CHK_W-1:0]  addra,   // Slot being written
   input  logic [rename_pkg::CKPT_W-1:0] dina,    // Map and avail snapshot
   output logic [rename_pkg::CKPT_W-1:0] douta,   // Read back of the port A slot
   input  logic [rename_pkg::CHK_W-1:0]  addrb,   // Slot to roll back to
   output logic [rename_pkg::CKPT_W-1:0] doutb    // Snapshot for the restore
);

   import rename_pkg::*;

   // Small enough to live in flops, which gives the zero cycle read on both ports
   logic [CKPT_W-1:0] mem [0:NCHECK-1];

   // ======================================
   // Write port A
   // ======================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NCHECK; i++) begin
            mem[i] <= '0;                       // Every slot starts blank
         end
      end else if (ena && wea) begin
         mem[addra] <= dina;                    // Snapshot taken at the branch edge
      end
   end

   // ======================================
   // Asynchronous reads
   // ======================================
   // A write and a read of the same slot in one cycle see the old contents
   always_comb begin
      douta = mem[addra];
      doutb = mem[addrb];
   end

endmodule

// File: rtl/free_list.sv
`timescale 1ns/1ns

module free_list (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        alloc_en,    // Accepted rename with a destination
   output logic [rename_pkg::PREG_W-1:0] alloc_preg,  // Lowest free preg
   output logic                        alloc_ok,    // At least one preg is free
   input  logic                        free_en,     // Commit releases a preg
   input  logic [rename_pkg::PREG_W-1:0] free_preg,
   output logic [rename_pkg::PREGS-1:0]  avail,       // One bit per preg, set when free
   input  logic                        load_en,     // Branch restore
   input  logic [rename_pkg::PREGS-1:0]  load_avail
);

   import rename_pkg::*;

   logic [PREGS-1:0] avail_nxt;

   // ======================================
   // Find first free
   // ======================================
   // Scanning from the top down leaves the lowest set bit as the winner
   always_comb begin
      alloc_preg = '0;
      for (int i = PREGS - 1; i >= 0; i--) begin
         if (avail[i]) begin
            alloc_preg = PREG_W'(i);
         end
      end
   end

   assign alloc_ok = |avail;                   // Empty list stalls a rename with a destination

   // ======================================
   // Next state of the bitmap
   // ======================================
   always_comb begin
      avail_nxt = load_en ? load_avail : avail;  // Restore replaces the whole bitmap
      if (alloc_en && alloc_ok) begin
         avail_nxt[alloc_preg] = 1'b0;          // Taken by this rename
      end
      // A free in the restore cycle still lands on top of the snapshot
      if (free_en) begin
         avail_nxt[free_preg] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Pregs below AREGS back the identity map and are busy from the start
         avail <= {PREGS{1'b1}} << AREGS;
      end else begin
         avail <= avail_nxt;
      end
   end

   // A double free would hand the same preg to two renames later on
   a_no_double_free : assert property (@(posedge clk) disable iff (!rst_n)
      free_en |-> !avail[free_preg])
      else $error("free_list: preg %0d freed while already free", free_preg);

endmodule

// File: rtl/rename_map.sv
`timescale 1ns/1ns

module rename_map (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [rename_pkg::AREG_W-1:0] src_a,      // First source lookup
   input  logic [rename_pkg::AREG_W-1:0] src_b,      // Second source lookup
   output logic [rename_pkg::PREG_W-1:0] phys_src_a,
   output logic [rename_pkg::PREG_W-1:0] phys_src_b,
   input  logic                        wr_en,      // Accepted rename with a destination
   input  logic [rename_pkg::AREG_W-1:0] wr_areg,
   input  logic [rename_pkg::PREG_W-1:0] wr_preg,
   output logic [rename_pkg::MAP_W-1:0]  map_flat,   // Whole table for the checkpoint
   input  logic                        load_en,    // Branch restore
   input  logic [rename_pkg::MAP_W-1:0]  load_map
);

   import rename_pkg::*;

   logic [PREG_W-1:0] map [0:AREGS-1];         // Current speculative mapping

   // ======================================
   // Table update
   // ======================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Identity mapping, so the low pregs hold the committed state at start
         for (int i = 0; i < AREGS; i++) begin
            map[i] <= PREG_W'(i);
         end
      end else if (load_en) begin
         for (int i = 0; i < AREGS; i++) begin
            map[i] <= load_map[i*PREG_W +: PREG_W];   // Roll every entry back at once
         end
      end else if (wr_en) begin
         map[wr_areg] <= wr_preg;               // Only the destination entry moves
      end
   end

   // ======================================
   // Lookups
   // ======================================
   always_comb begin
      phys_src_a = map[src_a];                  // Sources see the map before this rename
      phys_src_b = map[src_b];
   end

   always_comb begin
      for (int i = 0; i < AREGS; i++) begin
         map_flat[i*PREG_W +: PREG_W] = map[i];
      end
   end

   // A restore in the same cycle as a rename would drop one of the two updates
   a_no_wr_on_load : assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_en && load_en))
      else $error("rename_map: rename write during restore");

endmodule

// File: rtl/rename_pkg.sv
package rename_pkg;

   // ======================================
   // Architectural register file
   // ======================================
   localparam int AREGS  = 8;                   // Registers visible to software
   localparam int AREG_W = 3;                   // Bits to name one of them

   // ======================================
   // Physical register file
   // ======================================
   localparam int PREGS  = 32;                  // Rename pool including the reset mapping
   localparam int PREG_W = 5;                   // Bits to name one physical register

   // ======================================
   // Branch checkpoints
   // ======================================
   localparam int NCHECK = 4;                   // Unresolved branches in flight
   localparam int CHK_W  = 2;                   // Slot index width

   // Map table flattened entry by entry, entry 0 in the low bits
   localparam int MAP_W  = AREGS * PREG_W;

   // One snapshot holds the map in the low bits and the avail bitmap above it
   localparam int CKPT_W = MAP_W + PREGS;

endpackage

// File: rtl/rename_top.sv
`timescale 1ns/1ns

module rename_top (
   input  logic                        clk,
   input  logic                        rst_n,
   // Rename request
   input  logic                        rename_valid,
   input  logic [rename_pkg::AREG_W-1:0] src_a,
   input  logic [rename_pkg::AREG_W-1:0] src_b,
   input  logic [rename_pkg::AREG_W-1:0] dst,
   input  logic                        has_dst,
   // Branch checkpoints
   input  logic                        chk_take,
   input  logic                        resolve_valid,
   input  logic                        restore_valid,
   input  logic [rename_pkg::CHK_W-1:0]  restore_id,
   // Commit
   input  logic                        free_valid,
   input  logic [rename_pkg::PREG_W-1:0] free_preg,
   // Rename result
   output logic [rename_pkg::PREG_W-1:0] phys_src_a,
   output logic [rename_pkg::PREG_W-1:0] phys_src_b,
   output logic [rename_pkg::PREG_W-1:0] phys_dst,
   output logic                        stall,
   output logic [rename_pkg::CHK_W-1:0]  chk_id,
   output logic                        chk_full
);

   import rename_pkg::*;

   logic              rename_go;              // Rename accepted this cycle
   logic              dst_write;              // Accepted rename that needs a preg
   logic [PREG_W-1:0] alloc_preg;
   logic              alloc_ok;
   logic [MAP_W-1:0]  map_flat;
   logic [PREGS-1:0]  avail;
   logic [CKPT_W-1:0] ckpt_wr;                // Snapshot written on a take
   logic [CKPT_W-1:0] ckpt_rd;                // Snapshot read for a restore

   // ======================================
   // Rename gating
   // ======================================
   assign stall     = has_dst && !alloc_ok;   // Only a destination needs a free preg
   assign rename_go = rename_valid && !stall;
   assign dst_write = rename_go && has_dst;
   assign phys_dst  = alloc_preg;             // Shown even when the rename is held off
   assign ckpt_wr   = {avail, map_flat};

   rename_map rename_map_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .src_a      (src_a),
      .src_b      (src_b),
      .phys_src_a (phys_src_a),
      .phys_src_b (phys_src_b),
      .wr_en      (dst_write),
      .wr_areg    (dst),
      .wr_preg    (alloc_preg),
      .map_flat   (map_flat),
      .load_en    (restore_valid),
      .load_map   (ckpt_rd[MAP_W-1:0])        // Map sits in the low bits
   );

   free_list free_list_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .alloc_en   (dst_write),
      .alloc_preg (alloc_preg),
      .alloc_ok   (alloc_ok),
      .free_en    (free_valid),
      .free_preg  (free_preg),
      .avail      (avail),
      .load_en    (restore_valid),
      .load_avail (ckpt_rd[CKPT_W-1:MAP_W])
   );

   checkpoint_alloc checkpoint_alloc_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .take       (chk_take),
      .resolve    (resolve_valid),
      .restore    (restore_valid),
      .restore_id (restore_id),
      .chk_id     (chk_id),
      .chk_full   (chk_full)
   );

   // Port A writes the slot at the tail, port B serves the restore read
   checkpoint_ram checkpoint_ram_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (chk_take || restore_valid),
      .wea   (chk_take),
      .addra (chk_id),
      .dina  (ckpt_wr),
      .douta (),
      .addrb (restore_id),
      .doutb (ckpt_rd)
   );

   // A snapshot must see a stable map, and a restore must not race a rename
   a_ops_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({chk_take, rename_valid, restore_valid}))
      else $error("rename_top: take, rename and restore overlap");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the rename testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rename_tb -f rename.f -o rename_sim \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rename_sim > sim.log 2>&1

grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }
